/* filelist.f */
+incdir+tests
src/sweep_pkg.sv
src/nco.sv
src/correlator.sv
src/dispatcher_ctl.sv
src/dispatcher.sv
src/sweep_top.sv
tests/tb_sweep.sv

/* tests/tb_model.svh */
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// sample k is the input of the k-th cycle after a restart pulse.
bit stim [0:STIM_LEN-1];

// walks the windows of one search over stim and returns the first result.
task automatic predict_result(
    input  int offset,
    output bit found,
    output int metric,
    output int last_win
);
    int word;
    int ph_i;
    int ph_q;
    int acc_i;
    int acc_q;
    int st_i;
    int st_q;
    bit sgn_i;
    bit sgn_q;
    bit last_i;
    bit last_q;
    bit end_i;
    bit end_q;
    int len_i;
    int len_q;
    bit q_turn;
    int total;
    int runs;
    int win;
    int k;
    int run_max;
    int metric_max;

    run_max    = (1 << sweep_pkg::RUN_W) - 1;
    metric_max = (1 << sweep_pkg::METRIC_W) - 1;
    word       = (int'(BASE_WORD) + offset) & 16'hffff;
    ph_i       = 0;
    ph_q       = int'(sweep_pkg::QUAD_PHASE);
    acc_i      = 0;
    acc_q      = 0;
    last_i     = 0;
    last_q     = 0;
    len_i      = 0;
    len_q      = 0;
    q_turn     = 0;
    total      = 0;
    runs       = 0;
    win        = 0;
    found      = 0;
    metric     = 0;
    last_win   = -1;
    for (k = 0; k < STIM_LEN && !found; k++) begin
        st_i  = (stim[k] == ((ph_i >> 15) & 1)) ? 1 : -1;
        st_q  = (stim[k] == ((ph_q >> 15) & 1)) ? 1 : -1;
        acc_i = acc_i + st_i;
        acc_q = acc_q + st_q;
        if (k % WIN_LEN == WIN_LEN - 1) begin
            sgn_i = (acc_i < 0);
            sgn_q = (acc_q < 0);
            acc_i = st_i; // the dump sample opens the next window too.
            acc_q = st_q;
            end_i = (sgn_i != last_i);
            end_q = (sgn_q != last_q);
            if (end_q && q_turn) begin
                total  = total + len_q;
                runs   = runs + 1;
                q_turn = 0;
            end else if (end_i && !q_turn) begin
                total  = total + len_i;
                runs   = runs + 1;
                q_turn = 1;
            end
            len_i  = end_i ? 1 : ((len_i < run_max) ? len_i + 1 : run_max);
            len_q  = end_q ? 1 : ((len_q < run_max) ? len_q + 1 : run_max);
            last_i = sgn_i;
            last_q = sgn_q;
            if (runs == RUN_COUNT) begin
                found    = 1;
                metric   = total >> RUNS_LOG2;
                metric   = (metric > metric_max) ? metric_max : metric;
                last_win = win;
            end
            win = win + 1;
        end
        ph_i = (ph_i + word) & 16'hffff;
        ph_q = (ph_q + word) & 16'hffff;
    end
endtask

`endif

/* tests/tb_sweep.sv */
`default_nettype none

module tb_sweep;

    localparam int WINDOW_LOG2 = 4;
    localparam int RUNS_LOG2   = 2;
    localparam sweep_pkg::phase_t BASE_WORD = 16'h0ffc;
    localparam sweep_pkg::phase_t SINE_WORD = 16'h1020; // just above the swept band.

    localparam int WIN_LEN        = 1 << WINDOW_LOG2;
    localparam int RUN_COUNT      = 1 << RUNS_LOG2;
    localparam int MAX_WINDOWS    = 2048;
    localparam int STIM_LEN       = MAX_WINDOWS * WIN_LEN;
    localparam int STALL_MAX      = 40;
    localparam int RESET_CYCLES   = 16;
    localparam int NUM_SEARCHES   = 28;
    localparam int SEARCH_LIMIT   = STIM_LEN + STALL_MAX + 8;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + 4 + NUM_SEARCHES * (SEARCH_LIMIT + 2);

    localparam int MODE_RANDOM = 0;
    localparam int MODE_SINE   = 1;
    localparam int MODE_CONST  = 2;

    logic               clk;
    logic               rst_in;
    logic               i_sig;
    logic               i_ready;
    logic               o_valid;
    sweep_pkg::metric_t o_metric;
    sweep_pkg::offset_t o_offset;

    int cycle_cnt;
    int exp_offset;
    int seed_var;

    `include "tb_model.svh"

    sweep_top #(
        .WINDOW_LOG2 (WINDOW_LOG2),
        .RUNS_LOG2   (RUNS_LOG2),
        .BASE_WORD   (BASE_WORD)
    ) DUT (
        .clk      (clk),
        .rst_in   (rst_in),
        .i_sig    (i_sig),
        .i_ready  (i_ready),
        .o_valid  (o_valid),
        .o_metric (o_metric),
        .o_offset (o_offset)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("sim failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("ERR %0t: %s is %0d, expected %0d", $time, what, got, exp));
        end
    endtask

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            abort_run($sformatf("timeout: no end of test after %0d cycles", cycle_cnt));
        end
    end

    task automatic build_stim(input int mode, input bit level);
        int                k;
        sweep_pkg::phase_t p;

        p = sweep_pkg::phase_t'($urandom); // reference sine starts at a random phase.
        for (k = 0; k < STIM_LEN; k++) begin
            if (mode == MODE_RANDOM) begin
                stim[k] = $urandom % 2;
            end else if (mode == MODE_SINE) begin
                stim[k] = ~p[15]; // high while the sine is non-negative.
                p       = p + SINE_WORD;
            end else begin
                stim[k] = level;
            end
        end
    endtask

    task automatic apply_reset();
        int n;

        rst_in  = 1'b1;
        i_ready = 1'b0;
        i_sig   = 1'b0;
        for (n = 0; n < RESET_CYCLES; n++) begin
            @(posedge clk);
            #1;
            check_value("o_valid during reset", o_valid, 0);
        end
        #1;
        rst_in = 1'b0; // the next cycle is the restart pulse.
    endtask

    // drives one search from the cycle after a restart and takes its result.
    task automatic run_search(input int mode, input bit level, input bit hold_ready,
                              input int stall);
        int k;
        bit found;
        int exp_metric;
        int last_win;
        int first_valid;
        bit seen;
        bit accepted;
        bit ready_now;
        int stall_left;
        int held_metric;
        int held_offset;

        build_stim(mode, level);
        predict_result(exp_offset, found, exp_metric, last_win);
        if (!found && mode == MODE_CONST) begin
            $display("note: offset %0d finds no result on a constant input, using random samples",
                     exp_offset);
            build_stim(MODE_RANDOM, 1'b0);
            predict_result(exp_offset, found, exp_metric, last_win);
        end
        if (!found) begin
            abort_run("model found no result within the stimulus length");
        end
        // dump ends the window, then latch, update, report.
        first_valid = last_win * WIN_LEN + WIN_LEN - 1 + 3;
        seen        = 1'b0;
        accepted    = 1'b0;
        stall_left  = stall;
        k           = 0;
        while (!accepted) begin
            @(posedge clk);
            #1;
            if (k >= SEARCH_LIMIT) begin
                abort_run($sformatf("DUT gave no result within %0d cycles", SEARCH_LIMIT));
            end
            if (o_valid) begin
                if (!seen) begin
                    check_value("first o_valid cycle", k, first_valid);
                    check_value("o_metric", o_metric, exp_metric);
                    check_value("o_offset", o_offset, exp_offset);
                    held_metric = o_metric;
                    held_offset = o_offset;
                    seen        = 1'b1;
                end else begin
                    check_value("o_metric while stalled", o_metric, held_metric);
                    check_value("o_offset while stalled", o_offset, held_offset);
                end
            end else if (seen) begin
                check_value("o_valid while stalled", o_valid, 1);
            end
            ready_now = hold_ready || (seen && stall_left == 0);
            accepted  = o_valid && ready_now;
            if (o_valid && !ready_now) begin
                stall_left = stall_left - 1;
            end
            #1;
            i_sig   = (k < STIM_LEN) ? stim[k] : 1'b0;
            i_ready = ready_now;
            k       = k + 1;
        end
        @(posedge clk);
        #1;
        check_value("o_valid after transfer", o_valid, 0);
        #1;
        i_sig      = 1'b0;
        i_ready    = 1'b0;
        exp_offset = (exp_offset + 1) % 8;
    endtask

    task automatic first_result_after_reset();
        apply_reset();
        run_search(MODE_RANDOM, 1'b0, 1'b1, 0);
    endtask

    task automatic offset_sweep_wraps();
        int n;

        for (n = 0; n < 8; n++) begin
            run_search(MODE_RANDOM, 1'b0, 1'b1, 0);
        end
    endtask

    task automatic sine_metrics();
        int n;

        for (n = 0; n < 8; n++) begin
            run_search(MODE_SINE, 1'b0, 1'b1, 0);
        end
    endtask

    task automatic stalled_output_holds();
        int n;
        int stall;

        for (n = 0; n < 3; n++) begin
            stall = $urandom % STALL_MAX + 1;
            run_search(MODE_SINE, 1'b0, 1'b0, stall);
        end
    endtask

    task automatic constant_input_metrics();
        int n;

        for (n = 0; n < 8; n++) begin
            run_search(MODE_CONST, n[0], 1'b1, 0);
        end
    endtask

    initial begin
        rst_in     = 1'b1;
        i_sig      = 1'b0;
        i_ready    = 1'b0;
        cycle_cnt  = 0;
        exp_offset = 0;
        seed_var   = 32'h13d0;
        void'($urandom(seed_var));
        first_result_after_reset();
        offset_sweep_wraps();
        sine_metrics();
        stalled_output_holds();
        constant_input_metrics();
        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

/* src/sweep_top.sv */
`default_nettype none

module sweep_top #(
    parameter int                WINDOW_LOG2 = 4,
    parameter int                RUNS_LOG2   = 4,
    parameter sweep_pkg::phase_t BASE_WORD   = 16'h0ffc
) (
    input  wire                clk,
    input  wire                rst_in,
    input  wire                i_sig,
    input  wire                i_ready,
    output logic               o_valid,
    output sweep_pkg::metric_t o_metric,
    output sweep_pkg::offset_t o_offset
);

    logic               code_i;
    logic               code_q;
    logic               sign_i;
    logic               sign_q;
    logic               dump;
    logic               restart;
    logic               accept;
    sweep_pkg::offset_t nco_offset;

    nco #(
        .BASE_WORD  (BASE_WORD),
        .PHASE_INIT ('0)
    ) i_nco (
        .clk       (clk),
        .rst_in    (rst_in),
        .i_restart (restart),
        .i_offset  (nco_offset),
        .o_code    (code_i)
    );

    nco #(
        .BASE_WORD  (BASE_WORD),
        .PHASE_INIT (sweep_pkg::QUAD_PHASE)
    ) q_nco (
        .clk       (clk),
        .rst_in    (rst_in),
        .i_restart (restart),
        .i_offset  (nco_offset),
        .o_code    (code_q)
    );

    correlator #(
        .WINDOW_LOG2 (WINDOW_LOG2)
    ) i_corr (
        .clk       (clk),
        .rst_in    (rst_in),
        .i_restart (restart),
        .i_sig     (i_sig),
        .i_code    (code_i),
        .i_dump    (dump),
        .o_sign    (sign_i)
    );

    correlator #(
        .WINDOW_LOG2 (WINDOW_LOG2)
    ) q_corr (
        .clk       (clk),
        .rst_in    (rst_in),
        .i_restart (restart),
        .i_sig     (i_sig),
        .i_code    (code_q),
        .i_dump    (dump),
        .o_sign    (sign_q)
    );

    dispatcher_ctl #(
        .WINDOW_LOG2 (WINDOW_LOG2)
    ) ctl (
        .clk       (clk),
        .rst_in    (rst_in),
        .i_accept  (accept),
        .o_dump    (dump),
        .o_restart (restart)
    );

    dispatcher #(
        .RUNS_LOG2 (RUNS_LOG2)
    ) disp (
        .clk             (clk),
        .rst_in          (rst_in),
        .i_dump          (dump),
        .i_sign_i        (sign_i),
        .i_sign_q        (sign_q),
        .i_ready         (i_ready),
        .o_offset        (nco_offset),
        .o_accept        (accept),
        .o_valid         (o_valid),
        .o_metric        (o_metric),
        .o_report_offset (o_offset)
    );

endmodule

`default_nettype wire

/* src/dispatcher.sv */
`default_nettype none

module dispatcher #(
    parameter int RUNS_LOG2 = 4
) (
    input  wire                   clk,
    input  wire                   rst_in,
    input  wire                   i_dump,
    input  wire                   i_sign_i,
    input  wire                   i_sign_q,
    input  wire                   i_ready,
    output sweep_pkg::offset_t    o_offset,
    output logic                  o_accept,
    output logic                  o_valid,
    output sweep_pkg::metric_t    o_metric,
    output sweep_pkg::offset_t    o_report_offset
);

    localparam logic [RUNS_LOG2:0] LAST_RUN = {1'b0, {RUNS_LOG2{1'b1}}};

    sweep_pkg::disp_state_t state;
    sweep_pkg::offset_t     offset_r;

    // signs sampled in LATCH.
    logic new_i;
    logic new_q;

    // per channel run tracking.
    logic            last_i;
    logic            last_q;
    sweep_pkg::run_t run_i;
    sweep_pkg::run_t run_q;

    // alternating summation.
    logic               turn_q;
    sweep_pkg::sum_t    sum_r;
    logic [RUNS_LOG2:0] run_cnt;

    logic            chg_i;
    logic            chg_q;
    logic            take_i;
    logic            take_q;
    sweep_pkg::run_t add_len;
    sweep_pkg::sum_t shifted;

    always_comb begin
        chg_i   = (new_i != last_i);
        chg_q   = (new_q != last_q);
        take_q  = chg_q && turn_q;   // q has the turn and its run just ended.
        take_i  = chg_i && !turn_q;
        add_len = take_q ? run_q : run_i;
    end

    always_ff @(posedge clk) begin
        if (state == sweep_pkg::LATCH) begin
            new_i <= i_sign_i;
            new_q <= i_sign_q;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_in) begin
            state    <= sweep_pkg::IDLE;
            offset_r <= '0;
        end else begin
            case (state)
                sweep_pkg::IDLE: begin
                    if (i_dump) begin
                        state <= sweep_pkg::LATCH;
                    end
                end
                sweep_pkg::LATCH: begin
                    state <= sweep_pkg::UPDATE; // signs are valid one cycle after dump.
                end
                sweep_pkg::UPDATE: begin
                    if ((take_i || take_q) && run_cnt == LAST_RUN) begin
                        state <= sweep_pkg::REPORT;
                    end else begin
                        state <= sweep_pkg::IDLE;
                    end
                end
                sweep_pkg::REPORT: begin
                    // dumps are ignored here, the search waits on the consumer.
                    if (i_ready) begin
                        state    <= sweep_pkg::IDLE;
                        offset_r <= offset_r + 1'b1; // wraps after 8 offsets.
                    end
                end
                default: begin
                    state <= sweep_pkg::IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst_in || o_accept) begin
            last_i  <= 1'b0;
            last_q  <= 1'b0;
            run_i   <= '0;
            run_q   <= '0;
            turn_q  <= 1'b0; // i channel has the first turn.
            sum_r   <= '0;
            run_cnt <= '0;
        end else if (state == sweep_pkg::UPDATE) begin
            last_i <= new_i;
            last_q <= new_q;
            if (chg_i) begin
                run_i <= 8'd1;
            end else if (run_i != '1) begin
                run_i <= run_i + 1'b1;
            end
            if (chg_q) begin
                run_q <= 8'd1;
            end else if (run_q != '1) begin
                run_q <= run_q + 1'b1;
            end
            if (take_q || take_i) begin
                sum_r   <= sum_r + sweep_pkg::sum_t'(add_len);
                run_cnt <= run_cnt + 1'b1;
                turn_q  <= take_i;
            end
        end
    end

    assign shifted = sum_r >> RUNS_LOG2;

    // average run length, clipped to the metric width.
    assign o_metric = (|shifted[sweep_pkg::SUM_W-1:sweep_pkg::METRIC_W]) ?
                      '1 : shifted[sweep_pkg::METRIC_W-1:0];

    assign o_valid         = (state == sweep_pkg::REPORT);
    assign o_accept        = o_valid && i_ready;
    assign o_offset        = offset_r;
    assign o_report_offset = offset_r;

    stall_holds_result: assert property (
        @(posedge clk) disable iff (rst_in)
        o_valid && !i_ready |=> o_valid && $stable(o_metric) && $stable(o_report_offset)
    );

endmodule

`default_nettype wire

/* src/dispatcher_ctl.sv */
`default_nettype none

module dispatcher_ctl #(
    parameter int WINDOW_LOG2 = 4
) (
    input  wire  clk,
    input  wire  rst_in,
    input  wire  i_accept,
    output logic o_dump,
    output logic o_restart
);

    localparam logic [WINDOW_LOG2-1:0] PRE_WRAP = {{(WINDOW_LOG2-1){1'b1}}, 1'b0};

    logic [WINDOW_LOG2-1:0] win_cnt;
    logic                   dump_r;
    logic                   restart_r;

    always_ff @(posedge clk) begin
        if (rst_in) begin
            win_cnt   <= '0;
            dump_r    <= 1'b0;
            restart_r <= 1'b1; // held through reset, one more cycle after.
        end else if (restart_r) begin
            win_cnt   <= '0;
            dump_r    <= 1'b0;
            restart_r <= i_accept;
        end else begin
            win_cnt   <= win_cnt + 1'b1;
            // an accepted result restarts the datapath instead of closing a window.
            dump_r    <= (win_cnt == PRE_WRAP) && !i_accept;
            restart_r <= i_accept;
        end
    end

    assign o_dump    = dump_r;
    assign o_restart = restart_r;

    // a restart never meets a dump, and the first window after it is full length.
    first_dump_after_restart: assert property (
        @(posedge clk) disable iff (rst_in)
        o_restart |-> !o_dump ##1 !o_dump [* ((1 << WINDOW_LOG2) - 1)] ##1 o_dump
    );

endmodule

`default_nettype wire

/* src/correlator.sv */
`default_nettype none

module correlator #(
    parameter int WINDOW_LOG2 = 4
) (
    input  wire  clk,
    input  wire  rst_in,
    input  wire  i_restart,
    input  wire  i_sig,
    input  wire  i_code,
    input  wire  i_dump,
    output logic o_sign
);

    sweep_pkg::corr_t acc_r;
    sweep_pkg::corr_t step;
    sweep_pkg::corr_t sum_now;

    // +1 on agreement, -1 on disagreement.
    assign step    = (i_sig == i_code) ? 8'sd1 : -8'sd1;
    assign sum_now = acc_r + step;

    always_ff @(posedge clk) begin
        if (rst_in || i_restart) begin
            acc_r  <= '0;
            o_sign <= 1'b0;
        end else if (i_dump) begin
            o_sign <= sum_now[sweep_pkg::CORR_W-1]; // sign of the closing window.
            acc_r  <= step;                          // next window picks up this sample.
        end else begin
            acc_r  <= sum_now;
        end
    end

    // a restart realigns the window counter, so a full window must pass first.
    restart_then_full_window: assert property (
        @(posedge clk) disable iff (rst_in)
        i_restart |=> !i_dump [* ((1 << WINDOW_LOG2) - 1)]
    );

endmodule

`default_nettype wire

/* src/nco.sv */
`default_nettype none

module nco #(
    parameter sweep_pkg::phase_t BASE_WORD  = 16'h0ffc,
    parameter sweep_pkg::phase_t PHASE_INIT = 16'h0000
) (
    input  wire                  clk,
    input  wire                  rst_in,
    input  wire                  i_restart,
    input  wire sweep_pkg::offset_t i_offset,
    output logic                 o_code
);

    sweep_pkg::phase_t phase_r;
    sweep_pkg::phase_t freq_word;

    // the trial offset is a small step on top of the base word.
    assign freq_word = BASE_WORD + sweep_pkg::phase_t'(i_offset);

    always_ff @(posedge clk) begin
        if (rst_in || i_restart) begin
            phase_r <= PHASE_INIT; // every offset starts from a known phase.
        end else begin
            phase_r <= phase_r + freq_word;
        end
    end

    assign o_code = phase_r[sweep_pkg::PHASE_W-1]; // square wave from the msb.

endmodule

`default_nettype wire

/* src/sweep_pkg.sv */
`default_nettype none

package sweep_pkg;

    localparam int PHASE_W  = 16;
    localparam int CORR_W   = 8;
    localparam int RUN_W    = 8;
    localparam int SUM_W    = 20;
    localparam int OFFSET_W = 3;
    localparam int METRIC_W = 8;

    typedef logic [PHASE_W-1:0]         phase_t;  // nco phase, frequency and phase words.
    typedef logic signed [CORR_W-1:0]   corr_t;   // running agreement count.
    typedef logic [RUN_W-1:0]           run_t;    // sign run length in windows.
    typedef logic [SUM_W-1:0]           sum_t;    // accumulated run lengths.
    typedef logic [OFFSET_W-1:0]        offset_t; // trial frequency offset.
    typedef logic [METRIC_W-1:0]        metric_t; // average run length.

    // quarter turn between the I and Q oscillators.
    localparam phase_t QUAD_PHASE = 16'h4000;

    typedef enum logic [1:0] {
        IDLE,   // waiting for a dump.
        LATCH,  // sample the correlator signs.
        UPDATE, // advance run lengths and the sum.
        REPORT  // result held on the output.
    } disp_state_t;

endpackage

`default_nettype wire
